// File: hw/ising_pkg.sv
// shared widths, APB map and defaults; a J row (num_spin_p * bit_j_p) must fit in 32 bits
package ising_pkg;

    ////////////////////
    // default sizes
    ////////////////////
    parameter int NUM_SPIN   = 8;   // spins in the problem
    parameter int BIT_J      = 4;   // signed coupling width
    parameter int BIT_H      = 8;   // signed bias width
    parameter int FLIP_DEPTH = 16;  // flip list entries

    parameter int APB_ADDR_W = 12;
    parameter int APB_DATA_W = 32;

    typedef logic [APB_ADDR_W-1:0] apb_addr_t;  // byte address
    typedef logic [APB_DATA_W-1:0] apb_data_t;

    ////////////////////
    // register map
    ////////////////////
    parameter apb_addr_t CTRL_OFS      = 12'h000;  // bit0 start, bit1 clear done
    parameter apb_addr_t STATUS_OFS    = 12'h004;  // bit0 busy, bit1 done
    parameter apb_addr_t FLIP_CNT_OFS  = 12'h008;
    parameter apb_addr_t SPIN_INIT_OFS = 12'h00C;
    parameter apb_addr_t SPIN_RES_OFS  = 12'h010;  // live spin vector

    // memory regions, one 32-bit word per entry
    parameter apb_addr_t H_BASE    = 12'h080;
    parameter apb_addr_t J_BASE    = 12'h100;
    parameter apb_addr_t FLIP_BASE = 12'h200;

endpackage

// File: hw/ising_coupling_mem.sv
// flop storage, combinational reads; host indices are expected in range when strobed
`timescale 1ns/1ps

module ising_coupling_mem #(
    parameter int num_spin_p   = ising_pkg::NUM_SPIN,
    parameter int bit_j_p      = ising_pkg::BIT_J,
    parameter int bit_h_p      = ising_pkg::BIT_H,
    parameter int flip_depth_p = ising_pkg::FLIP_DEPTH,
    localparam int idx_w = $clog2(num_spin_p),
    localparam int ptr_w = $clog2(flip_depth_p),
    localparam int rd_w  = (idx_w > ptr_w) ? idx_w : ptr_w,
    localparam int row_w = num_spin_p * bit_j_p
) (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 j_we_i,
    input  logic                 h_we_i,
    input  logic [rd_w-1:0]      wr_idx_i,
    input  ising_pkg::apb_data_t wr_data_i,
    input  logic                 compute_sel_i,
    input  logic [rd_w-1:0]      rd_idx_i,
    input  logic [idx_w-1:0]     eng_idx_i,
    output logic [row_w-1:0]     j_row_o,
    output logic [bit_h_p-1:0]   h_val_o
);
    logic [row_w-1:0]   j_mem [num_spin_p];  // row i holds J_ij at bit j*bit_j_p
    logic [bit_h_p-1:0] h_mem [num_spin_p];
    logic [rd_w-1:0]    sel_idx;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < num_spin_p; i++) begin
                j_mem[i] <= '0;
                h_mem[i] <= '0;
            end
        end else begin
            if (j_we_i) j_mem[wr_idx_i[idx_w-1:0]] <= wr_data_i[row_w-1:0];
            if (h_we_i) h_mem[wr_idx_i[idx_w-1:0]] <= wr_data_i[bit_h_p-1:0];
        end
    end

    // load mode serves host readback, compute mode serves the engine
    always_comb begin
        case (compute_sel_i)
            1'b0:    sel_idx = rd_idx_i;
            default: sel_idx = rd_w'(eng_idx_i);
        endcase
    end

    always_comb begin
        j_row_o = '0;
        h_val_o = '0;
        if (int'(sel_idx) < num_spin_p) begin
            j_row_o = j_mem[sel_idx[idx_w-1:0]];
            h_val_o = h_mem[sel_idx[idx_w-1:0]];
        end
    end

endmodule

// File: hw/ising_flip_mem.sv
// one write port, two combinational read ports; entries hold spin indices only
`timescale 1ns/1ps

module ising_flip_mem #(
    parameter int num_spin_p   = ising_pkg::NUM_SPIN,
    parameter int flip_depth_p = ising_pkg::FLIP_DEPTH,
    localparam int idx_w = $clog2(num_spin_p),
    localparam int ptr_w = $clog2(flip_depth_p),
    localparam int rd_w  = (idx_w > ptr_w) ? idx_w : ptr_w
) (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 flip_we_i,
    input  logic [rd_w-1:0]      flip_wr_idx_i,
    input  ising_pkg::apb_data_t flip_wr_data_i,
    input  logic [ptr_w-1:0]     flip_ptr_i,
    output logic [idx_w-1:0]     flip_idx_o,
    input  logic [rd_w-1:0]      rd_idx_i,
    output logic [idx_w-1:0]     flip_idx_rd_o
);
    logic [idx_w-1:0] flip_mem [flip_depth_p];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < flip_depth_p; i++) begin
                flip_mem[i] <= '0;
            end
        end else if (flip_we_i) begin
            flip_mem[flip_wr_idx_i[ptr_w-1:0]] <= flip_wr_data_i[idx_w-1:0];
        end
    end

    assign flip_idx_o = flip_mem[flip_ptr_i];  // engine port

    // host readback, out-of-range reads give 0
    assign flip_idx_rd_o = (int'(rd_idx_i) < flip_depth_p) ? flip_mem[rd_idx_i[ptr_w-1:0]]
                                                           : '0;

endmodule

// File: hw/ising_spin_engine.sv
// sequential single-spin update, two cycles per flip; flip_cnt_i must stay stable while busy
`timescale 1ns/1ps

module ising_spin_engine #(
    parameter int num_spin_p   = ising_pkg::NUM_SPIN,
    parameter int bit_j_p      = ising_pkg::BIT_J,
    parameter int bit_h_p      = ising_pkg::BIT_H,
    parameter int flip_depth_p = ising_pkg::FLIP_DEPTH,
    localparam int idx_w = $clog2(num_spin_p),
    localparam int ptr_w = $clog2(flip_depth_p),
    localparam int cnt_w = $clog2(flip_depth_p + 1)
) (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic                          start_i,
    input  logic [cnt_w-1:0]              flip_cnt_i,
    input  logic [num_spin_p-1:0]         spin_init_i,
    input  logic [idx_w-1:0]              flip_idx_i,
    input  logic [num_spin_p*bit_j_p-1:0] j_row_i,
    input  logic [bit_h_p-1:0]            h_val_i,
    output logic [ptr_w-1:0]              flip_ptr_o,
    output logic [idx_w-1:0]              eng_idx_o,
    output logic                          compute_sel_o,
    output logic                          busy_o,
    output logic                          done_pulse_o,
    output logic [num_spin_p-1:0]         spin_vec_o
);
    // enough headroom for num_spin_p couplings plus the bias
    localparam int sum_w = bit_j_p + idx_w + 1;
    localparam int fw    = ((sum_w > bit_h_p) ? sum_w : bit_h_p) + 1;

    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        UPDATE
    } state_e;

    state_e                state_q;
    logic [cnt_w-1:0]      step_q;
    logic [idx_w-1:0]      cur_idx_q;
    logic [num_spin_p-1:0] spin_q;
    logic signed [fw-1:0]  field;
    logic                  last;

    assign last          = step_q == flip_cnt_i;
    assign busy_o        = state_q != IDLE;
    assign compute_sel_o = busy_o;
    assign done_pulse_o  = (state_q == FETCH) && last;
    assign flip_ptr_o    = step_q[ptr_w-1:0];
    assign eng_idx_o     = cur_idx_q;
    assign spin_vec_o    = spin_q;

    ////////////////////
    // local field
    ////////////////////
    // h_i + sum over j != i of +-J_ij, sign taken from s_j
    always_comb begin : field_calc
        logic signed [bit_j_p-1:0] j_c;
        field = $signed(h_val_i);
        for (int j = 0; j < num_spin_p; j++) begin
            j_c = $signed(j_row_i[j*bit_j_p +: bit_j_p]);
            if (idx_w'(j) != cur_idx_q) begin
                if (spin_q[j]) field = field + j_c;
                else           field = field - j_c;
            end
        end
    end

    ////////////////////
    // control
    ////////////////////
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q   <= IDLE;
            step_q    <= '0;
            cur_idx_q <= '0;
            spin_q    <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        spin_q  <= spin_init_i;
                        step_q  <= '0;
                        state_q <= FETCH;
                    end
                end
                FETCH: begin
                    if (last) begin
                        state_q <= IDLE;  // done_pulse_o is high in this cycle
                    end else begin
                        cur_idx_q <= flip_idx_i;
                        state_q   <= UPDATE;
                    end
                end
                UPDATE: begin
                    spin_q[cur_idx_q] <= ~field[fw-1];  // field >= 0 gives 1
                    step_q            <= step_q + 1'b1;
                    state_q           <= FETCH;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    a_idx_range: assert property (@(posedge clk_i) disable iff (rst_i)
        state_q == UPDATE |-> int'(cur_idx_q) < num_spin_p);

    a_done_exit: assert property (@(posedge clk_i) disable iff (rst_i)
        done_pulse_o |-> busy_o ##1 !busy_o);

endmodule

// File: hw/ising_apb_regs.sv
// word accesses only (paddr_i[1:0] ignored); no wait states; num_spin_p must not exceed 32
`timescale 1ns/1ps

module ising_apb_regs #(
    parameter int num_spin_p   = ising_pkg::NUM_SPIN,
    parameter int bit_j_p      = ising_pkg::BIT_J,
    parameter int bit_h_p      = ising_pkg::BIT_H,
    parameter int flip_depth_p = ising_pkg::FLIP_DEPTH,
    localparam int idx_w = $clog2(num_spin_p),
    localparam int ptr_w = $clog2(flip_depth_p),
    localparam int cnt_w = $clog2(flip_depth_p + 1),
    localparam int rd_w  = (idx_w > ptr_w) ? idx_w : ptr_w
) (
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  ising_pkg::apb_addr_t         paddr_i,
    input  logic                         psel_i,
    input  logic                         penable_i,
    input  logic                         pwrite_i,
    input  ising_pkg::apb_data_t         pwdata_i,
    output ising_pkg::apb_data_t         prdata_o,
    output logic                         pready_o,
    output logic                         pslverr_o,
    input  logic                         busy_i,
    input  logic                         done_pulse_i,
    input  logic [num_spin_p-1:0]        spin_vec_i,
    input  logic [num_spin_p*bit_j_p-1:0] j_row_i,
    input  logic [bit_h_p-1:0]           h_val_i,
    input  logic [idx_w-1:0]             flip_idx_rd_i,
    output logic                         start_o,
    output logic [cnt_w-1:0]             flip_cnt_o,
    output logic [num_spin_p-1:0]        spin_init_o,
    output logic                         j_we_o,
    output logic                         h_we_o,
    output logic                         flip_we_o,
    output logic [rd_w-1:0]              wr_idx_o,
    output ising_pkg::apb_data_t         wr_data_o,
    output logic [rd_w-1:0]              rd_idx_o,
    output logic                         irq_o
);
    import ising_pkg::*;

    logic      access, wr_ok, err, reg_hit, done_q;
    logic      h_hit, j_hit, flip_hit, mem_hit, busy_err, cnt_err;
    apb_addr_t h_ofs, j_ofs, f_ofs, ofs;
    apb_data_t reg_rdata;

    assign access = psel_i & penable_i;

    ////////////////////
    // region decode
    ////////////////////
    // addresses below a base wrap to a large offset and miss
    assign h_ofs    = (paddr_i - H_BASE) >> 2;
    assign j_ofs    = (paddr_i - J_BASE) >> 2;
    assign f_ofs    = (paddr_i - FLIP_BASE) >> 2;
    assign h_hit    = h_ofs < apb_addr_t'(num_spin_p);
    assign j_hit    = j_ofs < apb_addr_t'(num_spin_p);
    assign flip_hit = f_ofs < apb_addr_t'(flip_depth_p);
    assign mem_hit  = h_hit | j_hit | flip_hit;
    assign ofs      = flip_hit ? f_ofs : (h_hit ? h_ofs : j_ofs);

    always_comb begin
        reg_hit   = 1'b1;
        reg_rdata = '0;
        case (paddr_i)
            CTRL_OFS:      reg_rdata = '0;  // start and clear are self-clearing
            STATUS_OFS:    reg_rdata = apb_data_t'({done_q, busy_i});
            FLIP_CNT_OFS:  reg_rdata = apb_data_t'(flip_cnt_o);
            SPIN_INIT_OFS: reg_rdata = apb_data_t'(spin_init_o);
            SPIN_RES_OFS:  reg_rdata = apb_data_t'(spin_vec_i);
            default:       reg_hit = 1'b0;
        endcase
    end

    // error rules
    assign busy_err = pwrite_i & busy_i
                    & (mem_hit | paddr_i == FLIP_CNT_OFS | paddr_i == SPIN_INIT_OFS);
    assign cnt_err  = pwrite_i & (paddr_i == FLIP_CNT_OFS)
                    & (pwdata_i > apb_data_t'(flip_depth_p));
    assign err      = ~(reg_hit | mem_hit) | busy_err | cnt_err;

    assign wr_ok     = access & pwrite_i & ~err;
    assign pready_o  = 1'b1;
    assign pslverr_o = access & err;

    ////////////////////
    // writes
    ////////////////////
    assign j_we_o    = wr_ok & j_hit;
    assign h_we_o    = wr_ok & h_hit;
    assign flip_we_o = wr_ok & flip_hit;
    assign wr_idx_o  = ofs[rd_w-1:0];
    assign rd_idx_o  = ofs[rd_w-1:0];
    assign wr_data_o = pwdata_i;
    assign start_o   = wr_ok & (paddr_i == CTRL_OFS) & pwdata_i[0] & ~busy_i;
    assign irq_o     = done_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            flip_cnt_o  <= '0;
            spin_init_o <= '0;
            done_q      <= 1'b0;
        end else begin
            if (wr_ok && paddr_i == FLIP_CNT_OFS) flip_cnt_o <= pwdata_i[cnt_w-1:0];
            if (wr_ok && paddr_i == SPIN_INIT_OFS) spin_init_o <= pwdata_i[num_spin_p-1:0];
            if (done_pulse_i) begin
                done_q <= 1'b1;
            end else if (start_o || (wr_ok && paddr_i == CTRL_OFS && pwdata_i[1])) begin
                done_q <= 1'b0;  // a new run also drops the old done
            end
        end
    end

    // readback, zero outside a read access
    always_comb begin
        prdata_o = '0;
        if (access && !pwrite_i) begin
            if (reg_hit)       prdata_o = reg_rdata;
            else if (h_hit)    prdata_o = apb_data_t'($signed(h_val_i));
            else if (j_hit)    prdata_o = apb_data_t'(j_row_i);
            else if (flip_hit) prdata_o = apb_data_t'(flip_idx_rd_i);
        end
    end

    // the engine must take an accepted start in the next cycle
    a_start_busy: assert property (@(posedge clk_i) disable iff (rst_i)
        start_o |=> busy_i);

endmodule

// File: hw/ising_core_top.sv
// num_spin_p and flip_depth_p must be at least 2, num_spin_p at most 32, J row at most 32 bits
`timescale 1ns/1ps

module ising_core_top #(
    parameter int num_spin_p   = ising_pkg::NUM_SPIN,
    parameter int bit_j_p      = ising_pkg::BIT_J,
    parameter int bit_h_p      = ising_pkg::BIT_H,
    parameter int flip_depth_p = ising_pkg::FLIP_DEPTH
) (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  ising_pkg::apb_addr_t paddr_i,
    input  logic                 psel_i,
    input  logic                 penable_i,
    input  logic                 pwrite_i,
    input  ising_pkg::apb_data_t pwdata_i,
    output ising_pkg::apb_data_t prdata_o,
    output logic                 pready_o,
    output logic                 pslverr_o,
    output logic                 irq_o
);
    import ising_pkg::*;

    localparam int idx_w = $clog2(num_spin_p);
    localparam int ptr_w = $clog2(flip_depth_p);
    localparam int cnt_w = $clog2(flip_depth_p + 1);
    localparam int rd_w  = (idx_w > ptr_w) ? idx_w : ptr_w;
    localparam int row_w = num_spin_p * bit_j_p;

    // host side
    logic              j_we;
    logic              h_we;
    logic              flip_we;
    logic [rd_w-1:0]   wr_idx;
    logic [rd_w-1:0]   rd_idx;
    apb_data_t         wr_data;
    logic [row_w-1:0]  j_row;
    logic [bit_h_p-1:0] h_val;
    logic [idx_w-1:0]  flip_idx_rd;

    // engine side
    logic                  start;
    logic                  busy;
    logic                  done_pulse;
    logic                  compute_sel;
    logic [cnt_w-1:0]      flip_cnt;
    logic [num_spin_p-1:0] spin_init;
    logic [num_spin_p-1:0] spin_vec;
    logic [idx_w-1:0]      eng_idx;
    logic [ptr_w-1:0]      flip_ptr;
    logic [idx_w-1:0]      flip_idx;

    ising_apb_regs #(
        .num_spin_p   (num_spin_p  ),
        .bit_j_p      (bit_j_p     ),
        .bit_h_p      (bit_h_p     ),
        .flip_depth_p (flip_depth_p)
    ) i_regs (
        .clk_i, .rst_i,
        .paddr_i, .psel_i, .penable_i, .pwrite_i, .pwdata_i,
        .prdata_o, .pready_o, .pslverr_o,
        .busy_i        (busy       ),
        .done_pulse_i  (done_pulse ),
        .spin_vec_i    (spin_vec   ),
        .j_row_i       (j_row      ),
        .h_val_i       (h_val      ),
        .flip_idx_rd_i (flip_idx_rd),
        .start_o       (start      ),
        .flip_cnt_o    (flip_cnt   ),
        .spin_init_o   (spin_init  ),
        .j_we_o        (j_we       ),
        .h_we_o        (h_we       ),
        .flip_we_o     (flip_we    ),
        .wr_idx_o      (wr_idx     ),
        .wr_data_o     (wr_data    ),
        .rd_idx_o      (rd_idx     ),
        .irq_o
    );

    ising_coupling_mem #(
        .num_spin_p   (num_spin_p  ),
        .bit_j_p      (bit_j_p     ),
        .bit_h_p      (bit_h_p     ),
        .flip_depth_p (flip_depth_p)
    ) i_coupling_mem (
        .clk_i, .rst_i,
        .j_we_i        (j_we       ),
        .h_we_i        (h_we       ),
        .wr_idx_i      (wr_idx     ),
        .wr_data_i     (wr_data    ),
        .compute_sel_i (compute_sel),  // high while the engine runs
        .rd_idx_i      (rd_idx     ),
        .eng_idx_i     (eng_idx    ),
        .j_row_o       (j_row      ),
        .h_val_o       (h_val      )
    );

    ising_flip_mem #(
        .num_spin_p   (num_spin_p  ),
        .flip_depth_p (flip_depth_p)
    ) i_flip_mem (
        .clk_i, .rst_i,
        .flip_we_i      (flip_we    ),
        .flip_wr_idx_i  (wr_idx     ),
        .flip_wr_data_i (wr_data    ),
        .flip_ptr_i     (flip_ptr   ),
        .flip_idx_o     (flip_idx   ),
        .rd_idx_i       (rd_idx     ),
        .flip_idx_rd_o  (flip_idx_rd)
    );

    ising_spin_engine #(
        .num_spin_p   (num_spin_p  ),
        .bit_j_p      (bit_j_p     ),
        .bit_h_p      (bit_h_p     ),
        .flip_depth_p (flip_depth_p)
    ) i_engine (
        .clk_i, .rst_i,
        .start_i       (start      ),
        .flip_cnt_i    (flip_cnt   ),
        .spin_init_i   (spin_init  ),
        .flip_idx_i    (flip_idx   ),
        .j_row_i       (j_row      ),
        .h_val_i       (h_val      ),
        .flip_ptr_o    (flip_ptr   ),
        .eng_idx_o     (eng_idx    ),
        .compute_sel_o (compute_sel),
        .busy_o        (busy       ),
        .done_pulse_o  (done_pulse ),
        .spin_vec_o    (spin_vec   )
    );

endmodule

// File: tests/ising_checker.sv
// expects the testbench to flag each access that must fail; the shadow copy follows accepted writes
`timescale 1ns/1ps

module ising_checker #(
    parameter int num_spin_p   = ising_pkg::NUM_SPIN,
    parameter int bit_j_p      = ising_pkg::BIT_J,
    parameter int bit_h_p      = ising_pkg::BIT_H,
    parameter int flip_depth_p = ising_pkg::FLIP_DEPTH
) (
    input  logic                 clk_i,
    input  logic                 psel_i,
    input  logic                 penable_i,
    input  logic                 pwrite_i,
    input  ising_pkg::apb_addr_t paddr_i,
    input  ising_pkg::apb_data_t pwdata_i,
    input  ising_pkg::apb_data_t prdata_i,
    input  logic                 pready_i,
    input  logic                 pslverr_i,
    input  logic                 irq_i,
    input  logic                 exp_err_i,     // this access must be refused
    input  logic                 chk_status_i,  // compare STATUS against exp_status_i
    input  logic [1:0]           exp_status_i,
    output int                   check_cnt_o,
    output int                   err_cnt_o
);
    import ising_pkg::*;

    localparam int idx_w = $clog2(num_spin_p);
    localparam int row_w = num_spin_p * bit_j_p;

    // shadow of the problem as the host wrote it
    logic [row_w-1:0]      sh_j [num_spin_p];
    logic [bit_h_p-1:0]    sh_h [num_spin_p];
    logic [idx_w-1:0]      sh_flip [flip_depth_p];
    logic [num_spin_p-1:0] sh_init;
    int                    sh_cnt;

    initial begin
        for (int i = 0; i < num_spin_p; i++) begin
            sh_j[i] = '0;
            sh_h[i] = '0;
        end
        for (int k = 0; k < flip_depth_p; k++) begin
            sh_flip[k] = '0;
        end
        sh_init     = '0;
        sh_cnt      = 0;
        check_cnt_o = 0;
        err_cnt_o   = 0;
    end

    ////////////////////
    // reference model
    ////////////////////
    // walk the flip list, s_i = 1 when h_i + sum of J_ij * (+1/-1) over j != i is >= 0
    function automatic logic [num_spin_p-1:0] ref_spins();
        logic [num_spin_p-1:0] s;
        int                    i;
        int                    field;
        int                    jv;
        s = sh_init;
        for (int k = 0; k < sh_cnt; k++) begin
            i     = int'(sh_flip[k]);
            field = $signed(sh_h[i]);
            for (int j = 0; j < num_spin_p; j++) begin
                jv = $signed(sh_j[i][j*bit_j_p +: bit_j_p]);
                if (j != i) begin
                    field += s[j] ? jv : -jv;
                end
            end
            s[i] = (field >= 0);
        end
        return s;
    endfunction

    // word index inside a region, -1 when outside
    function automatic int region_idx(input apb_addr_t a, input apb_addr_t base, input int n);
        if (int'(a) < int'(base) || int'(a) >= int'(base) + 4 * n) begin
            return -1;
        end
        return (int'(a) - int'(base)) >> 2;
    endfunction

    task automatic compare(input string what, input apb_data_t got, input apb_data_t exp);
        check_cnt_o++;
        if (got !== exp) begin
            err_cnt_o++;
            $display("CHECK FAILED at %0t: %s gave %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic shadow_write(input apb_addr_t a, input apb_data_t d);
        int hi;
        int ji;
        int fi;
        hi = region_idx(a, H_BASE, num_spin_p);
        ji = region_idx(a, J_BASE, num_spin_p);
        fi = region_idx(a, FLIP_BASE, flip_depth_p);
        if (a == FLIP_CNT_OFS) sh_cnt = int'(d);
        if (a == SPIN_INIT_OFS) sh_init = d[num_spin_p-1:0];
        if (hi >= 0) sh_h[hi] = d[bit_h_p-1:0];
        if (ji >= 0) sh_j[ji] = d[row_w-1:0];
        if (fi >= 0) sh_flip[fi] = d[idx_w-1:0];
    endtask

    task automatic check_read(input apb_addr_t a, input apb_data_t d);
        apb_data_t exp;
        int        hi;
        int        ji;
        int        fi;
        hi  = region_idx(a, H_BASE, num_spin_p);
        ji  = region_idx(a, J_BASE, num_spin_p);
        fi  = region_idx(a, FLIP_BASE, flip_depth_p);
        exp = '0;  // CTRL reads as zero
        if (a == STATUS_OFS) begin
            if (chk_status_i) begin
                compare("STATUS", d & 32'h3, apb_data_t'(exp_status_i));
                compare("irq_o", apb_data_t'(irq_i), apb_data_t'(exp_status_i[1]));
            end
            return;  // polling reads are not compared
        end
        if (a == FLIP_CNT_OFS) exp = apb_data_t'(sh_cnt);
        if (a == SPIN_INIT_OFS) exp = apb_data_t'(sh_init);
        if (a == SPIN_RES_OFS) exp = apb_data_t'(ref_spins());
        if (hi >= 0) exp = apb_data_t'($signed(sh_h[hi]));  // h reads back sign-extended
        if (ji >= 0) exp = apb_data_t'(sh_j[ji]);
        if (fi >= 0) exp = apb_data_t'(sh_flip[fi]);
        compare($sformatf("read of %h", a), d, exp);
    endtask

    // one compare per access phase
    always @(posedge clk_i) begin
        if (psel_i && penable_i) begin
            compare("pready", apb_data_t'(pready_i), 32'h1);
            compare($sformatf("pslverr at %h", paddr_i), apb_data_t'(pslverr_i),
                    apb_data_t'(exp_err_i));
            if (!exp_err_i) begin
                if (pwrite_i) shadow_write(paddr_i, pwdata_i);
                else          check_read(paddr_i, prdata_i);
            end
        end
    end

endmodule

// File: tests/tb_ising_core.sv
// runs with the package default sizes; the tie problem is built for 8 spins of 4-bit couplings
`timescale 1ns/1ps

module tb_ising_core;
    import ising_pkg::*;

    localparam int num_spin_p   = NUM_SPIN;
    localparam int bit_j_p      = BIT_J;
    localparam int bit_h_p      = BIT_H;
    localparam int flip_depth_p = FLIP_DEPTH;
    localparam int xfer_limit   = 20;   // cycles to wait for pready
    localparam int poll_limit   = 200;  // STATUS reads per run

    logic       clk;
    logic       rst;
    logic       psel;
    logic       penable;
    logic       pwrite;
    apb_addr_t  paddr;
    apb_data_t  pwdata;
    apb_data_t  prdata;
    logic       pready;
    logic       pslverr;
    logic       irq;
    logic       exp_err;
    logic       chk_status;
    logic [1:0] exp_status;
    apb_data_t  rdata;      // last read data
    int         check_cnt;
    int         err_cnt;
    int         err_mark;
    int         tests_ok;
    int         tests_bad;
    bit         hung;

    always #2 clk = ~clk;

    ising_core_top #(
        .num_spin_p   (num_spin_p  ),
        .bit_j_p      (bit_j_p     ),
        .bit_h_p      (bit_h_p     ),
        .flip_depth_p (flip_depth_p)
    ) i_dut (
        .clk_i     (clk    ),
        .rst_i     (rst    ),
        .paddr_i   (paddr  ),
        .psel_i    (psel   ),
        .penable_i (penable),
        .pwrite_i  (pwrite ),
        .pwdata_i  (pwdata ),
        .prdata_o  (prdata ),
        .pready_o  (pready ),
        .pslverr_o (pslverr),
        .irq_o     (irq    )
    );

    ising_checker #(
        .num_spin_p   (num_spin_p  ),
        .bit_j_p      (bit_j_p     ),
        .bit_h_p      (bit_h_p     ),
        .flip_depth_p (flip_depth_p)
    ) i_chk (
        .clk_i        (clk       ),
        .psel_i       (psel      ),
        .penable_i    (penable   ),
        .pwrite_i     (pwrite    ),
        .paddr_i      (paddr     ),
        .pwdata_i     (pwdata    ),
        .prdata_i     (prdata    ),
        .pready_i     (pready    ),
        .pslverr_i    (pslverr   ),
        .irq_i        (irq       ),
        .exp_err_i    (exp_err   ),
        .chk_status_i (chk_status),
        .exp_status_i (exp_status),
        .check_cnt_o  (check_cnt ),
        .err_cnt_o    (err_cnt   )
    );

    ////////////////////
    // bus tasks
    ////////////////////
    // setup phase, then access phase; starts and ends on a falling edge
    task automatic apb_xfer(input bit wr, input apb_addr_t addr, input apb_data_t wdata = '0,
                            input bit err = 1'b0);
        int n;
        if (hung) return;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        exp_err = err;
        @(negedge clk);
        penable = 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!pready && n < xfer_limit);
        rdata = prdata;
        if (!pready) begin
            $display("APB transfer to %h got no pready within %0d cycles", addr, xfer_limit);
            hung = 1'b1;
        end
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        exp_err = 1'b0;
    endtask

    task automatic check_status(input logic [1:0] exp);
        chk_status = 1'b1;
        exp_status = exp;
        apb_xfer(1'b0, STATUS_OFS);
        chk_status = 1'b0;
    endtask

    task automatic wait_done();
        int n;
        n     = 0;
        rdata = '0;
        while (!hung && !rdata[1] && n < poll_limit) begin
            apb_xfer(1'b0, STATUS_OFS);
            n++;
        end
        if (!hung && !rdata[1]) begin
            $display("run did not set done within %0d STATUS reads", poll_limit);
            hung = 1'b1;
        end
    endtask

    ////////////////////
    // problems and runs
    ////////////////////
    task automatic load_problem();
        for (int i = 0; i < num_spin_p; i++) begin
            apb_xfer(1'b1, J_BASE + apb_addr_t'(4 * i), $urandom);
            apb_xfer(1'b1, H_BASE + apb_addr_t'(4 * i), $urandom);
        end
        for (int k = 0; k < flip_depth_p; k++) begin
            apb_xfer(1'b1, FLIP_BASE + apb_addr_t'(4 * k), $urandom % num_spin_p);
        end
        apb_xfer(1'b1, SPIN_INIT_OFS, $urandom);
    endtask

    task automatic read_problem();
        for (int i = 0; i < num_spin_p; i++) begin
            apb_xfer(1'b0, J_BASE + apb_addr_t'(4 * i));
            apb_xfer(1'b0, H_BASE + apb_addr_t'(4 * i));
        end
        for (int k = 0; k < flip_depth_p; k++) begin
            apb_xfer(1'b0, FLIP_BASE + apb_addr_t'(4 * k));
        end
        apb_xfer(1'b0, SPIN_INIT_OFS);
        apb_xfer(1'b0, FLIP_CNT_OFS);
    endtask

    // spin 0: h=2, J_01=J_02=1, s1=s2=0 gives field 0; spin 1 sees an all-zero row
    task automatic load_tie_problem();
        for (int i = 0; i < num_spin_p; i++) begin
            apb_xfer(1'b1, J_BASE + apb_addr_t'(4 * i), (i == 0) ? 32'h0000_0110 : 32'h0);
            apb_xfer(1'b1, H_BASE + apb_addr_t'(4 * i), (i == 0) ? 32'h2 : 32'h0);
        end
        apb_xfer(1'b1, FLIP_BASE, 32'h0);
        apb_xfer(1'b1, FLIP_BASE + 12'h4, 32'h1);
        apb_xfer(1'b1, SPIN_INIT_OFS, 32'h0);
    endtask

    task automatic run_flips(input int cnt);
        apb_xfer(1'b1, FLIP_CNT_OFS, apb_data_t'(cnt));
        apb_xfer(1'b1, CTRL_OFS, 32'h1);
        wait_done();
        apb_xfer(1'b0, SPIN_RES_OFS);  // checker compares with the reference
    endtask

    task automatic finish_test(input string name);
        if (err_cnt == err_mark && !hung) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: failed with %0d mismatches", name, err_cnt - err_mark);
        end
        err_mark = err_cnt;
    endtask

    ////////////////////
    // sequence
    ////////////////////
    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        exp_err    = 1'b0;
        chk_status = 1'b0;
        exp_status = 2'b00;
        rdata      = '0;
        hung       = 1'b0;
        err_mark   = 0;
        tests_ok   = 0;
        tests_bad  = 0;
        void'($urandom(32'h206a_fa35));
        repeat (16) @(negedge clk);
        rst = 1'b0;

        check_status(2'b00);  // idle, no done, no irq
        read_problem();       // all zero after reset
        load_problem();
        read_problem();
        finish_test("readback");

        load_problem();
        run_flips(1);
        finish_test("single_flip");

        repeat (4) begin
            load_problem();
            run_flips(flip_depth_p);
        end
        finish_test("full_list");

        load_tie_problem();
        run_flips(2);
        finish_test("tie");

        apb_xfer(1'b1, SPIN_INIT_OFS, $urandom);
        run_flips(0);
        check_status(2'b10);
        finish_test("zero_count");

        // writes during a run are refused and change nothing
        load_problem();
        apb_xfer(1'b1, FLIP_CNT_OFS, apb_data_t'(flip_depth_p));
        apb_xfer(1'b1, CTRL_OFS, 32'h1);
        check_status(2'b01);
        apb_xfer(1'b1, J_BASE, $urandom, 1'b1);
        apb_xfer(1'b1, H_BASE + 12'h4, $urandom, 1'b1);
        apb_xfer(1'b1, FLIP_BASE + 12'h8, $urandom, 1'b1);
        apb_xfer(1'b1, SPIN_INIT_OFS, $urandom, 1'b1);
        apb_xfer(1'b1, FLIP_CNT_OFS, 32'h1, 1'b1);
        wait_done();
        apb_xfer(1'b0, SPIN_RES_OFS);
        read_problem();
        apb_xfer(1'b0, 12'h040, '0, 1'b1);  // unmapped
        apb_xfer(1'b1, 12'h3f0, $urandom, 1'b1);
        apb_xfer(1'b1, FLIP_CNT_OFS, apb_data_t'(flip_depth_p + 1), 1'b1);
        apb_xfer(1'b0, FLIP_CNT_OFS);
        finish_test("refusal");

        check_status(2'b10);
        apb_xfer(1'b1, CTRL_OFS, 32'h2);  // clear done
        check_status(2'b00);
        finish_test("irq_clear");

        $display("tests: %0d ok, %0d failed; checks: %0d, mismatches: %0d",
                 tests_ok, tests_bad, check_cnt, err_cnt);
        if (tests_bad == 0 && err_cnt == 0 && !hung && check_cnt > 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: sources.f
hw/ising_pkg.sv
hw/ising_coupling_mem.sv
hw/ising_flip_mem.sv
hw/ising_spin_engine.sv
hw/ising_apb_regs.sv
hw/ising_core_top.sv
tests/ising_checker.sv
tests/tb_ising_core.sv

// File: Makefile
# Verilator build and run of the Ising core testbench
VERILATOR  ?= verilator
TOP        ?= tb_ising_core
FILELIST   ?= sources.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_MSG   ?= Everything OK

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(SIM_BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
